// File: drac_frontend_pkg.sv
// *************************************************
// Shared definitions for the decode-to-issue slice
//  - widths, vector typedefs and RV32 opcode values
//  - instruction class enum
//  - fetch, ID-to-IR stage and APB structs
//  - queue depth and register map
// *************************************************
package drac_frontend_pkg;

    // Depth must stay a power of two so indices wrap on their own
    localparam int IQ_NUM_ENTRIES = 8;
    localparam int IQ_IDX_W       = $clog2(IQ_NUM_ENTRIES);
    localparam int IQ_COUNT_W     = IQ_IDX_W + 1;   // Holds 0..IQ_NUM_ENTRIES

    localparam int XLEN       = 32;
    localparam int REG_IDX_W  = 5;
    localparam int APB_ADDR_W = 8;
    localparam int APB_DATA_W = 32;

    typedef logic [IQ_COUNT_W-1:0] iq_count_t;
    typedef logic [IQ_IDX_W-1:0]   iq_idx_t;
    typedef logic [XLEN-1:0]       pc_t;
    typedef logic [31:0]           instr_word_t;
    typedef logic [REG_IDX_W-1:0]  reg_idx_t;
    typedef logic [6:0]            opcode_t;
    typedef logic [APB_ADDR_W-1:0] apb_addr_t;
    typedef logic [APB_DATA_W-1:0] apb_data_t;

    // Major opcodes in bits 6:0 of the word
    localparam opcode_t OPC_OP     = 7'b0110011;
    localparam opcode_t OPC_OP_IMM = 7'b0010011;
    localparam opcode_t OPC_LUI    = 7'b0110111;
    localparam opcode_t OPC_AUIPC  = 7'b0010111;
    localparam opcode_t OPC_LOAD   = 7'b0000011;
    localparam opcode_t OPC_STORE  = 7'b0100011;
    localparam opcode_t OPC_BRANCH = 7'b1100011;
    localparam opcode_t OPC_JAL    = 7'b1101111;
    localparam opcode_t OPC_JALR   = 7'b1100111;
    localparam opcode_t OPC_SYSTEM = 7'b1110011;

    typedef enum logic [2:0] {
        CLS_ILLEGAL = 3'd0,
        CLS_ALU     = 3'd1,
        CLS_LOAD    = 3'd2,
        CLS_STORE   = 3'd3,
        CLS_BRANCH  = 3'd4,
        CLS_JUMP    = 3'd5,
        CLS_SYSTEM  = 3'd6
    } instr_class_e;

    typedef struct packed {
        pc_t         pc;
        instr_word_t word;
    } fetch_t;                    // 64 bits

    typedef struct packed {
        pc_t          pc;
        instr_word_t  word;
        instr_class_e cls;
        reg_idx_t     rd;
        reg_idx_t     rs1;
        reg_idx_t     rs2;
        logic         rd_we;      // Writes a nonzero rd
        logic         rs1_used;
        logic         rs2_used;
    } id_ir_stage_t;              // 85 bits

    typedef struct packed {
        logic      psel;
        logic      penable;
        logic      pwrite;
        apb_addr_t paddr;
        apb_data_t pwdata;
    } apb_req_t;

    typedef struct packed {
        apb_data_t prdata;
        logic      pready;
        logic      pslverr;
    } apb_rsp_t;

    // Register map
    localparam apb_addr_t REG_CTRL_ADDR   = 8'h00;
    localparam apb_addr_t REG_STATUS_ADDR = 8'h04;
    localparam apb_addr_t REG_ISSUED_ADDR = 8'h08;

    localparam int CTRL_HOLD_BIT    = 0;
    localparam int CTRL_FLUSH_BIT   = 1;  // Write-only and reads as zero
    localparam int STATUS_EMPTY_BIT = 4;  // Count sits in bits 3:0
    localparam int STATUS_FULL_BIT  = 5;

endpackage

// File: instr_decoder.sv
// *************************************************
// RV32 decoder, fetch record to ID-to-IR record
//  - opcode classification
//  - register index extraction and use flags
// *************************************************
`timescale 1ns/1ps

module instr_decoder (
    input  drac_frontend_pkg::fetch_t       fetch_i,   // PC and raw word from fetch
    output drac_frontend_pkg::id_ir_stage_t dec_o      // Decoded stage record
);

    drac_frontend_pkg::opcode_t opcode;
    logic                       writes_rd;   // Class may write rd, before the x0 check

    assign opcode = fetch_i.word[6:0];

    always_comb begin
        dec_o          = '0;
        writes_rd      = 1'b0;
        dec_o.pc       = fetch_i.pc;
        dec_o.word     = fetch_i.word;
        // Fixed field positions, meaningless fields are still copied
        dec_o.rd       = fetch_i.word[11:7];
        dec_o.rs1      = fetch_i.word[19:15];
        dec_o.rs2      = fetch_i.word[24:20];
        dec_o.cls      = drac_frontend_pkg::CLS_ILLEGAL;

        case (opcode)
            drac_frontend_pkg::OPC_OP: begin           // Register-register ALU
                dec_o.cls      = drac_frontend_pkg::CLS_ALU;
                dec_o.rs1_used = 1'b1;
                dec_o.rs2_used = 1'b1;
                writes_rd      = 1'b1;
            end
            drac_frontend_pkg::OPC_OP_IMM: begin
                dec_o.cls      = drac_frontend_pkg::CLS_ALU;
                dec_o.rs1_used = 1'b1;
                writes_rd      = 1'b1;
            end
            drac_frontend_pkg::OPC_LUI,
            drac_frontend_pkg::OPC_AUIPC: begin        // No source registers
                dec_o.cls = drac_frontend_pkg::CLS_ALU;
                writes_rd = 1'b1;
            end
            drac_frontend_pkg::OPC_LOAD: begin
                dec_o.cls      = drac_frontend_pkg::CLS_LOAD;
                dec_o.rs1_used = 1'b1;                 // Base address
                writes_rd      = 1'b1;
            end
            drac_frontend_pkg::OPC_STORE: begin
                dec_o.cls      = drac_frontend_pkg::CLS_STORE;
                dec_o.rs1_used = 1'b1;
                dec_o.rs2_used = 1'b1;                 // Store data
            end
            drac_frontend_pkg::OPC_BRANCH: begin
                dec_o.cls      = drac_frontend_pkg::CLS_BRANCH;
                dec_o.rs1_used = 1'b1;
                dec_o.rs2_used = 1'b1;
            end
            drac_frontend_pkg::OPC_JAL: begin
                dec_o.cls = drac_frontend_pkg::CLS_JUMP;
                writes_rd = 1'b1;                      // Link register
            end
            drac_frontend_pkg::OPC_JALR: begin
                dec_o.cls      = drac_frontend_pkg::CLS_JUMP;
                dec_o.rs1_used = 1'b1;
                writes_rd      = 1'b1;
            end
            drac_frontend_pkg::OPC_SYSTEM: dec_o.cls = drac_frontend_pkg::CLS_SYSTEM;
            default: dec_o.cls = drac_frontend_pkg::CLS_ILLEGAL;   // Classified only, no trap
        endcase

        // x0 as destination is never a real write
        dec_o.rd_we = writes_rd & (dec_o.rd != '0);
    end

endmodule

// File: instruction_queue.sv
// *************************************************
// Circular instruction queue between decode and issue
//  - head, tail and occupancy count
//  - valid/ready on both fetch and issue sides
//  - hold and flush from the register block
// *************************************************
`timescale 1ns/1ps

module instruction_queue (
    input  logic                              clk_i,
    input  logic                              rstn_i,

    input  logic                              fetch_valid_i,
    input  drac_frontend_pkg::id_ir_stage_t   dec_i,          // Decoded record to store
    output logic                              fetch_ready_o,

    input  logic                              issue_ready_i,
    output logic                              issue_valid_o,
    output drac_frontend_pkg::id_ir_stage_t   issue_o,        // Head record, zero when idle

    input  logic                              hold_i,         // Stall the issue side
    input  logic                              flush_i,        // Drop every entry
    output drac_frontend_pkg::iq_count_t      count_o,
    output logic                              deq_o           // Head pops on this edge
);

    drac_frontend_pkg::id_ir_stage_t buffer_q [drac_frontend_pkg::IQ_NUM_ENTRIES];

    drac_frontend_pkg::iq_idx_t   head_q;
    drac_frontend_pkg::iq_idx_t   tail_q;
    drac_frontend_pkg::iq_count_t count_q;

    logic empty;
    logic full;
    logic push;
    logic pop;

    assign empty = (count_q == '0);
    assign full  = (count_q == drac_frontend_pkg::iq_count_t'(drac_frontend_pkg::IQ_NUM_ENTRIES));

    // Full queue or flush in flight refuses new records
    assign fetch_ready_o = ~full & ~flush_i;
    assign issue_valid_o = ~empty & ~hold_i;

    assign push  = fetch_valid_i & fetch_ready_o;
    assign pop   = issue_valid_o & issue_ready_i;
    assign deq_o = pop;

    // Payload storage, written at the tail
    always_ff @(posedge clk_i) begin
        if (push) begin
            buffer_q[tail_q] <= dec_i;
        end
    end

    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            head_q  <= '0;
            tail_q  <= '0;
            count_q <= '0;
        end else if (flush_i) begin         // Wins over push and pop
            head_q  <= '0;
            tail_q  <= '0;
            count_q <= '0;
        end else begin
            head_q  <= head_q + drac_frontend_pkg::iq_idx_t'(pop);    // Wraps at depth
            tail_q  <= tail_q + drac_frontend_pkg::iq_idx_t'(push);
            count_q <= count_q + drac_frontend_pkg::iq_count_t'(push)
                               - drac_frontend_pkg::iq_count_t'(pop);
        end
    end

    assign issue_o = issue_valid_o ? buffer_q[head_q] : '0;
    assign count_o = count_q;

endmodule

// File: iq_apb_regs.sv
// *************************************************
// APB register block steering the instruction queue
//  - CTRL with hold and self-clearing flush
//  - STATUS with count, empty and full
//  - ISSUED counter of issue handshakes
// *************************************************
`timescale 1ns/1ps

module iq_apb_regs (
    input  logic                          clk_i,
    input  logic                          rstn_i,

    input  drac_frontend_pkg::apb_req_t   apb_req_i,
    output drac_frontend_pkg::apb_rsp_t   apb_rsp_o,

    input  drac_frontend_pkg::iq_count_t  count_i,   // Registered queue occupancy
    input  logic                          deq_i,     // One pulse per pop
    output logic                          hold_o,
    output logic                          flush_o    // One cycle after the CTRL write
);

    logic access;                 // Access phase of a transfer
    logic wr_en;
    logic rd_en;
    logic sel_ctrl;
    logic sel_status;
    logic sel_issued;
    logic addr_hit;
    logic ctrl_wr;
    logic q_empty;
    logic q_full;

    logic                         hold_q;
    logic                         flush_q;
    drac_frontend_pkg::apb_data_t issued_q;
    drac_frontend_pkg::apb_data_t ctrl_word;
    drac_frontend_pkg::apb_data_t status_word;

    assign access = apb_req_i.psel & apb_req_i.penable;
    assign wr_en  = access & apb_req_i.pwrite;
    assign rd_en  = access & ~apb_req_i.pwrite;

    assign sel_ctrl   = (apb_req_i.paddr == drac_frontend_pkg::REG_CTRL_ADDR);
    assign sel_status = (apb_req_i.paddr == drac_frontend_pkg::REG_STATUS_ADDR);
    assign sel_issued = (apb_req_i.paddr == drac_frontend_pkg::REG_ISSUED_ADDR);
    assign addr_hit   = sel_ctrl | sel_status | sel_issued;
    assign ctrl_wr    = wr_en & sel_ctrl;

    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            hold_q   <= 1'b0;
            flush_q  <= 1'b0;
            issued_q <= '0;
        end else begin
            if (ctrl_wr) begin
                hold_q <= apb_req_i.pwdata[drac_frontend_pkg::CTRL_HOLD_BIT];
            end
            // Pulse clears itself on the following edge
            flush_q <= ctrl_wr & apb_req_i.pwdata[drac_frontend_pkg::CTRL_FLUSH_BIT];
            if (deq_i) begin
                issued_q <= issued_q + 32'd1;   // Wraps silently
            end
        end
    end

    // Status flags straight from the count
    assign q_empty = (count_i == '0);
    assign q_full  = (count_i == drac_frontend_pkg::iq_count_t'(drac_frontend_pkg::IQ_NUM_ENTRIES));

    always_comb begin
        ctrl_word                                   = '0;
        ctrl_word[drac_frontend_pkg::CTRL_HOLD_BIT] = hold_q;   // Flush bit stays zero
        status_word                                 = '0;
        status_word[drac_frontend_pkg::IQ_COUNT_W-1:0]  = count_i;
        status_word[drac_frontend_pkg::STATUS_EMPTY_BIT] = q_empty;
        status_word[drac_frontend_pkg::STATUS_FULL_BIT]  = q_full;
    end

    // Read mux, zero outside a read access
    always_comb begin
        apb_rsp_o.prdata = '0;
        if (rd_en) begin
            if (sel_ctrl) begin
                apb_rsp_o.prdata = ctrl_word;
            end else if (sel_status) begin
                apb_rsp_o.prdata = status_word;
            end else if (sel_issued) begin
                apb_rsp_o.prdata = issued_q;
            end
        end
    end

    assign apb_rsp_o.pready  = access;   // No wait states
    // Unmapped address, or a write to anything but CTRL
    assign apb_rsp_o.pslverr = access & (~addr_hit | (apb_req_i.pwrite & ~sel_ctrl));

    assign hold_o  = hold_q;
    assign flush_o = flush_q;

endmodule

// File: id_iq_top.sv
// *************************************************
// Decode-to-issue top level
//  - instruction decoder
//  - instruction queue
//  - APB control and status registers
// *************************************************
`timescale 1ns/1ps

module id_iq_top (
    input  logic                             clk_i,
    input  logic                             rstn_i,

    input  logic                             fetch_valid_i,
    input  drac_frontend_pkg::fetch_t        fetch_i,
    output logic                             fetch_ready_o,

    input  logic                             issue_ready_i,
    output logic                             issue_valid_o,
    output drac_frontend_pkg::id_ir_stage_t  issue_o,

    input  drac_frontend_pkg::apb_req_t      apb_req_i,
    output drac_frontend_pkg::apb_rsp_t      apb_rsp_o
);

    drac_frontend_pkg::id_ir_stage_t dec;     // Decoder output, queue write data
    drac_frontend_pkg::iq_count_t    count;
    logic                            hold;
    logic                            flush;
    logic                            deq;

    instr_decoder decoder_i (
        .fetch_i (fetch_i),
        .dec_o   (dec)
    );

    instruction_queue queue_i (
        .clk_i         (clk_i),
        .rstn_i        (rstn_i),
        .fetch_valid_i (fetch_valid_i),
        .dec_i         (dec),
        .fetch_ready_o (fetch_ready_o),
        .issue_ready_i (issue_ready_i),
        .issue_valid_o (issue_valid_o),
        .issue_o       (issue_o),
        .hold_i        (hold),
        .flush_i       (flush),
        .count_o       (count),
        .deq_o         (deq)
    );

    // Register block watches the queue and steers it
    iq_apb_regs regs_i (
        .clk_i     (clk_i),
        .rstn_i    (rstn_i),
        .apb_req_i (apb_req_i),
        .apb_rsp_o (apb_rsp_o),
        .count_i   (count),
        .deq_i     (deq),
        .hold_o    (hold),
        .flush_o   (flush)
    );

endmodule

// File: tb_apb_tasks.svh
// *************************************************
// Testbench helper tasks
//  - RV32 field encoding
//  - fetch push with ready wait
//  - APB write and read with error capture
// *************************************************

// Fixed field positions, funct bits left at zero
function automatic drac_frontend_pkg::instr_word_t encode_instr(input logic [6:0] opcode,
                                                                input logic [4:0] rd,
                                                                input logic [4:0] rs1,
                                                                input logic [4:0] rs2);
    return {7'b0, rs2, rs1, 3'b000, rd, opcode};
endfunction

// Holds valid until the queue takes the record
task automatic push_fetch(input drac_frontend_pkg::instr_word_t word);
    logic done;
    done = 1'b0;
    @(posedge clk_i);
    #1;
    fetch_valid_i = 1'b1;
    fetch_i.pc    = next_pc;
    fetch_i.word  = word;
    while (!done) begin
        @(negedge clk_i);
        done = fetch_ready_o;           // Handshake on the coming edge
        @(posedge clk_i);
    end
    #1;
    fetch_valid_i = 1'b0;
    next_pc       = next_pc + 32'd4;
endtask

task automatic apb_write(input drac_frontend_pkg::apb_addr_t addr,
                         input drac_frontend_pkg::apb_data_t data, output logic err);
    @(posedge clk_i);
    #1;
    apb_req.psel    = 1'b1;             // Setup phase
    apb_req.penable = 1'b0;
    apb_req.pwrite  = 1'b1;
    apb_req.paddr   = addr;
    apb_req.pwdata  = data;
    @(posedge clk_i);
    #1;
    apb_req.penable = 1'b1;             // Access phase
    @(negedge clk_i);
    err = apb_rsp.pslverr;
    @(posedge clk_i);
    #1;
    apb_req = '0;
    if (!err && addr == drac_frontend_pkg::REG_CTRL_ADDR && data[1]) begin
        flush_seen = 1'b1;              // Queue empties on the next edge
    end
endtask

task automatic apb_read(input drac_frontend_pkg::apb_addr_t addr,
                        output drac_frontend_pkg::apb_data_t data, output logic err);
    @(posedge clk_i);
    #1;
    apb_req.psel    = 1'b1;
    apb_req.penable = 1'b0;
    apb_req.pwrite  = 1'b0;
    apb_req.paddr   = addr;
    apb_req.pwdata  = '0;
    @(posedge clk_i);
    #1;
    apb_req.penable = 1'b1;
    @(negedge clk_i);
    data = apb_rsp.prdata;              // Settled mid access cycle
    err  = apb_rsp.pslverr;
    @(posedge clk_i);
    #1;
    apb_req = '0;
endtask

// File: tb_id_iq_top.sv
// *************************************************
// Testbench for the decode-to-issue top level
//  - clock, reset and watchdog
//  - decode model and scoreboard monitor
//  - checking assertions and the six tests
// *************************************************
`timescale 1ns/1ps

module tb_id_iq_top;

    localparam int WATCHDOG_NS = 20000;     // About 600 test cycles at 8 ns with 4x margin
    localparam int REC_W       = $bits(drac_frontend_pkg::id_ir_stage_t);

    logic                            clk_i;
    logic                            rstn_i;
    logic                            fetch_valid_i;
    drac_frontend_pkg::fetch_t       fetch_i;
    logic                            fetch_ready_o;
    logic                            issue_ready_i;
    logic                            issue_valid_o;
    drac_frontend_pkg::id_ir_stage_t issue_o;
    drac_frontend_pkg::apb_req_t     apb_req;
    drac_frontend_pkg::apb_rsp_t     apb_rsp;

    drac_frontend_pkg::id_ir_stage_t sb [$];    // Expected records in push order
    drac_frontend_pkg::id_ir_stage_t exp_rec;
    drac_frontend_pkg::pc_t          next_pc;
    drac_frontend_pkg::apb_data_t    rdata;
    drac_frontend_pkg::instr_word_t  words [14];
    int          push_cyc [$];
    int          model_count;
    int          issue_count;
    int          cycle;
    int          latency;
    int          seed;
    int          errors;
    int          test_errors;
    int          tests_run;
    int          tests_failed;
    int          accepts;
    int          n;
    logic        flush_seen;
    logic        check_latency;
    logic        err;
    logic [31:0] rnd;
    string       test_name;

    id_iq_top dut_i (
        .clk_i         (clk_i),
        .rstn_i        (rstn_i),
        .fetch_valid_i (fetch_valid_i),
        .fetch_i       (fetch_i),
        .fetch_ready_o (fetch_ready_o),
        .issue_ready_i (issue_ready_i),
        .issue_valid_o (issue_valid_o),
        .issue_o       (issue_o),
        .apb_req_i     (apb_req),
        .apb_rsp_o     (apb_rsp)
    );

    `include "tb_apb_tasks.svh"

    always #4 clk_i = ~clk_i;

    task automatic report_error(input string what, input logic [REC_W-1:0] exp,
                                input logic [REC_W-1:0] act);
        errors++;
        test_errors++;
        $display("[ERROR] %s: %s expected %0h actual %0h", test_name, what, exp, act);
    endtask

    task automatic note_failure(input string what);
        errors++;
        test_errors++;
        $display("%s: %s", test_name, what);
    endtask

    task automatic check_word(input string what, input logic [31:0] exp, input logic [31:0] act);
        assert (exp == act) else report_error(what, REC_W'(exp), REC_W'(act));
    endtask

    task automatic check_flag(input string what, input logic exp, input logic act);
        assert (exp == act) else report_error(what, REC_W'(exp), REC_W'(act));
    endtask

    task automatic start_test(input string name);
        test_name   = name;
        test_errors = 0;
    endtask

    task automatic finish_test();
        tests_run++;
        if (test_errors != 0) begin
            tests_failed++;
            $display("test %s: FAIL with %0d errors", test_name, test_errors);
        end else begin
            $display("test %s: PASS", test_name);
        end
    endtask

    task automatic wait_drained(input int max_cycles);
        int k;
        k = 0;
        while (model_count != 0 && k < max_cycles) begin
            @(negedge clk_i);
            k++;
        end
        @(negedge clk_i);                       // Let the last update land
        check_flag("queue drained", 1'b1, model_count == 0);
    endtask

    // Expected stage record built from the RV32 decode rules
    function automatic drac_frontend_pkg::id_ir_stage_t expected_decode(
            input drac_frontend_pkg::fetch_t f);
        drac_frontend_pkg::id_ir_stage_t e;
        logic [6:0] op;
        op     = f.word[6:0];
        e      = '0;
        e.pc   = f.pc;
        e.word = f.word;
        e.rd   = f.word[11:7];
        e.rs1  = f.word[19:15];
        e.rs2  = f.word[24:20];
        if (op inside {7'b0110011, 7'b0010011, 7'b0110111, 7'b0010111})
            e.cls = drac_frontend_pkg::CLS_ALU;
        else if (op == 7'b0000011) e.cls = drac_frontend_pkg::CLS_LOAD;
        else if (op == 7'b0100011) e.cls = drac_frontend_pkg::CLS_STORE;
        else if (op == 7'b1100011) e.cls = drac_frontend_pkg::CLS_BRANCH;
        else if (op inside {7'b1101111, 7'b1100111}) e.cls = drac_frontend_pkg::CLS_JUMP;
        else if (op == 7'b1110011) e.cls = drac_frontend_pkg::CLS_SYSTEM;
        else e.cls = drac_frontend_pkg::CLS_ILLEGAL;
        e.rs1_used = (op == 7'b0110011) || (op == 7'b0010011) || (op == 7'b1100111)
                     || (op == 7'b0000011) || (op == 7'b0100011) || (op == 7'b1100011);
        e.rs2_used = (op == 7'b0110011) || (op == 7'b0100011) || (op == 7'b1100011);
        e.rd_we    = (e.cls inside {drac_frontend_pkg::CLS_ALU, drac_frontend_pkg::CLS_LOAD,
                                    drac_frontend_pkg::CLS_JUMP}) && (e.rd != 5'd0);
        return e;
    endfunction

    // Monitor samples at negedge as handshakes complete on the next rising edge
    always @(negedge clk_i) begin
        if (rstn_i) begin
            cycle++;
            if (issue_valid_o && issue_ready_i) begin
                issue_count++;
                if (sb.size() == 0) begin
                    note_failure("a record was issued while none was expected");
                end else begin
                    exp_rec = sb.pop_front();
                    latency = cycle - push_cyc.pop_front();
                    assert (issue_o == exp_rec)
                        else report_error("issued record", exp_rec, issue_o);
                    if (check_latency) begin
                        assert (latency == 1)
                            else report_error("issue latency", REC_W'(1), REC_W'(latency));
                    end
                end
            end
            if (fetch_valid_i && fetch_ready_o) begin
                sb.push_back(expected_decode(fetch_i));
                push_cyc.push_back(cycle);
            end
            if (flush_seen) begin               // Flush edge drops everything
                sb.delete();
                push_cyc.delete();
                flush_seen = 1'b0;
            end
            model_count <= sb.size();
        end
    end

    assert property (@(negedge clk_i) disable iff (!rstn_i) (issue_valid_o || issue_o == '0))
        else report_error("idle issue_o", '0, issue_o);
    assert property (@(negedge clk_i) disable iff (!rstn_i)
                     !(model_count == drac_frontend_pkg::IQ_NUM_ENTRIES && fetch_ready_o))
        else note_failure("fetch_ready_o stayed high with eight entries queued");
    assert property (@(negedge clk_i) disable iff (!rstn_i)
                     (!(apb_req.psel && apb_req.penable) || apb_rsp.pready))
        else note_failure("pready was low in an APB access phase");

    initial begin
        #WATCHDOG_NS;
        $display("timeout: the run did not finish within %0d ns", WATCHDOG_NS);
        $display("tests failed");
        $finish;
    end

    initial begin
        clk_i         = 1'b0;
        rstn_i        = 1'b0;
        fetch_valid_i = 1'b0;
        fetch_i       = '0;
        issue_ready_i = 1'b0;
        apb_req       = '0;
        next_pc       = 32'h0000_1000;
        seed          = 76313;
        issue_count   = 0;
        cycle         = 0;
        errors        = 0;
        test_errors   = 0;
        tests_run     = 0;
        tests_failed  = 0;
        flush_seen    = 1'b0;
        check_latency = 1'b0;
        repeat (16) @(posedge clk_i);
        #1 rstn_i = 1'b1;

        start_test("reset_state");
        @(negedge clk_i);
        check_flag("fetch_ready_o", 1'b1, fetch_ready_o);
        check_flag("issue_valid_o", 1'b0, issue_valid_o);
        apb_read(drac_frontend_pkg::REG_STATUS_ADDR, rdata, err);
        check_word("STATUS", 32'h10, rdata);
        check_flag("pslverr on STATUS read", 1'b0, err);
        apb_read(drac_frontend_pkg::REG_ISSUED_ADDR, rdata, err);
        check_word("ISSUED", 32'h0, rdata);
        finish_test();

        start_test("decode_rules");
        words[0]  = encode_instr(7'b0110011, 5'd3, 5'd1, 5'd2);     // ADD x3
        words[1]  = encode_instr(7'b0110011, 5'd0, 5'd4, 5'd5);     // ADD into x0
        words[2]  = encode_instr(7'b0010011, 5'd6, 5'd7, 5'd9);
        words[3]  = encode_instr(7'b0110111, 5'd8, 5'd10, 5'd11);   // LUI
        words[4]  = encode_instr(7'b0010111, 5'd9, 5'd12, 5'd13);
        words[5]  = encode_instr(7'b0000011, 5'd10, 5'd11, 5'd14);  // Load
        words[6]  = encode_instr(7'b0100011, 5'd12, 5'd13, 5'd14);
        words[7]  = encode_instr(7'b1100011, 5'd15, 5'd16, 5'd17);  // Branch
        words[8]  = encode_instr(7'b1101111, 5'd1, 5'd18, 5'd19);
        words[9]  = encode_instr(7'b1100111, 5'd0, 5'd20, 5'd21);   // JALR without link
        words[10] = encode_instr(7'b1110011, 5'd22, 5'd23, 5'd24);
        words[11] = encode_instr(7'b1111111, 5'd25, 5'd26, 5'd27);  // Unknown opcode
        words[12] = $random(seed);
        words[13] = $random(seed);
        issue_ready_i = 1'b1;
        check_latency = 1'b1;
        for (int i = 0; i < 14; i++) begin
            push_fetch(words[i]);
        end
        wait_drained(20);
        check_latency = 1'b0;
        finish_test();

        start_test("order_backpressure");
        issue_ready_i = 1'b0;
        accepts       = 0;
        @(posedge clk_i);
        #1 fetch_valid_i = 1'b1;
        fetch_i.pc   = next_pc;
        fetch_i.word = $random(seed);
        n = 0;
        while (n < 20) begin
            @(negedge clk_i);
            if (!fetch_ready_o) break;          // Full so stop pushing
            accepts++;
            n++;
            @(posedge clk_i);
            #1 next_pc = next_pc + 32'd4;
            fetch_i.pc   = next_pc;
            fetch_i.word = $random(seed);
        end
        @(posedge clk_i);
        #1 fetch_valid_i = 1'b0;
        check_word("accepts before full", 32'd8, accepts);
        apb_read(drac_frontend_pkg::REG_STATUS_ADDR, rdata, err);
        check_word("STATUS when full", 32'h28, rdata);
        n = 0;
        while (model_count != 0 && n < 200) begin
            @(posedge clk_i);
            #1 rnd = $random(seed);
            issue_ready_i = rnd[0];
            n++;
        end
        issue_ready_i = 1'b1;
        wait_drained(20);
        finish_test();

        start_test("hold");
        issue_ready_i = 1'b0;
        for (int i = 0; i < 3; i++) begin
            push_fetch($random(seed));
        end
        apb_write(drac_frontend_pkg::REG_CTRL_ADDR, 32'h1, err);
        issue_ready_i = 1'b1;
        repeat (6) begin
            @(negedge clk_i);
            check_flag("issue_valid_o under hold", 1'b0, issue_valid_o);
        end
        apb_read(drac_frontend_pkg::REG_STATUS_ADDR, rdata, err);
        check_word("STATUS under hold", 32'h3, rdata);
        apb_write(drac_frontend_pkg::REG_CTRL_ADDR, 32'h0, err);
        wait_drained(20);
        finish_test();

        start_test("flush_and_errors");
        issue_ready_i = 1'b0;
        for (int i = 0; i < 5; i++) begin
            push_fetch($random(seed));
        end
        apb_write(drac_frontend_pkg::REG_CTRL_ADDR, 32'h2, err);
        issue_ready_i = 1'b1;                   // Nothing may issue after the flush
        repeat (2) @(posedge clk_i);
        apb_read(drac_frontend_pkg::REG_STATUS_ADDR, rdata, err);
        check_word("STATUS after flush", 32'h10, rdata);
        apb_read(drac_frontend_pkg::REG_CTRL_ADDR, rdata, err);
        check_word("CTRL readback", 32'h0, rdata);
        apb_write(drac_frontend_pkg::REG_STATUS_ADDR, 32'hff, err);
        check_flag("pslverr on STATUS write", 1'b1, err);
        apb_read(8'h0c, rdata, err);
        check_flag("pslverr on unmapped read", 1'b1, err);
        finish_test();

        start_test("issued_counter");
        for (int i = 0; i < 200; i++) begin
            @(posedge clk_i);
            #1 rnd = $random(seed);
            fetch_valid_i = rnd[0];
            issue_ready_i = rnd[1] | rnd[2];    // Drain a bit faster than fill
            fetch_i.pc    = next_pc;
            fetch_i.word  = $random(seed);
            next_pc       = next_pc + 32'd4;
        end
        @(posedge clk_i);
        #1 fetch_valid_i = 1'b0;
        issue_ready_i = 1'b1;
        wait_drained(20);
        apb_read(drac_frontend_pkg::REG_ISSUED_ADDR, rdata, err);
        check_word("ISSUED", issue_count, rdata);
        finish_test();

        $display("summary: %0d tests run, %0d failing, %0d errors",
                 tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

// File: src.f
+incdir+.
drac_frontend_pkg.sv
instr_decoder.sv
instruction_queue.sv
iq_apb_regs.sv
id_iq_top.sv
tb_id_iq_top.sv

// File: run.sh
#!/usr/bin/env bash
# Builds the testbench with Verilator, runs it and checks the output
set -u

cd "$(dirname "$0")" || exit 1

if ! command -v verilator >/dev/null 2>&1; then
    echo "verilator is not on the PATH"
    exit 1
fi

verilator --binary --timing --assert --top-module tb_id_iq_top \
    -Mdir obj_dir -o sim_tb -f src.f
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

output=$(./obj_dir/sim_tb)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -qx "all tests passed"; then
    exit 0
fi
exit 1
